// ==== list.f ====
src/portalPkg.sv
src/burstSplitter.sv
src/beatFifo.sv
src/portalRead.sv
src/portalWrite.sv
src/portalTop.sv
test/tbClock.sv
test/tbPortal.sv

// ==== Makefile ====
# Verilator build and run for the portal bridge testbench.

VERILATOR ?= verilator
FLIST     ?= list.f
TOP       ?= tbPortal
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= Verification passed

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tbPortal.sv ====
`default_nettype none

module tbPortal import portalPkg::*; ();

  localparam int directedBursts = 22;
  localparam int mixedBursts    = 60;
  localparam int timeoutCycles  = (directedBursts + mixedBursts) * 200;

  logic                   CLK;
  logic                   RST_N;
  logic [addrWidth-1:0]   arAddr;
  logic [lenWidth-1:0]    arLen;
  logic [idWidth-1:0]     arId;
  logic                   arValid;
  logic                   arReady;
  logic [dataWidth-1:0]   rData;
  logic [idWidth-1:0]     rId;
  logic                   rLast;
  logic                   rValid;
  logic                   rReady;
  logic [addrWidth-1:0]   awAddr;
  logic [lenWidth-1:0]    awLen;
  logic [idWidth-1:0]     awId;
  logic                   awValid;
  logic                   awReady;
  logic [dataWidth-1:0]   wData;
  logic                   wValid;
  logic                   wReady;
  logic [idWidth-1:0]     bId;
  logic                   bValid;
  logic                   bReady;
  logic [dataWidth-1:0]   indData;
  logic                   indValid;
  logic                   indPop;
  logic                   reqReady;
  logic [dataWidth-1:0]   reqData;
  logic [methodWidth-1:0] reqMethod;
  logic                   reqPush;
  logic                   irq;

  int          errors = 0;
  int          indMode = 0;  // 0 low, 1 high, 2 random gaps.
  bit          reqGaps;
  bit          rGaps;
  bit          bGaps;
  bit          enModel;
  int          indHead = 0;
  int          popIndex = 0;
  logic [31:0] indWords [256];
  logic [38:0] expR [$];  // data, id, last.
  logic [5:0]  expB [$];
  logic [33:0] expReq [$];  // method, data.

  tbClock clockGen (.CLK (CLK), .RST_N (RST_N));

  portalTop dut0 (.*);

  task automatic logError(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  // expected read word from the register map.
  function automatic logic [31:0] refRead(input logic portalSel, input logic ctrl,
      input logic [4:0] off, input logic indLevel, input logic reqLevel,
      input logic enable, input logic [31:0] indWord);
    if (ctrl) begin
      case (off)
        5'h00, 5'h0C: return portalSel ? 32'd0 : 32'(indLevel);
        5'h04: return portalSel ? 32'd0 : 32'(enable);
        5'h08: return 32'd1;
        5'h10: return portalSel ? 32'd6 : 32'd5;
        5'h14: return 32'd2;
        default: return 32'd0;
      endcase
    end
    if (portalSel) return (off == 5'h04) ? 32'(reqLevel) : 32'd0;
    if (off == 5'h00) return indWord;
    return (off == 5'h04) ? 32'(indLevel) : 32'd0;
  endfunction

  function automatic logic [31:0] makeAddr(input logic portalSel, input logic [6:0] page,
      input logic [4:0] off);
    return {19'd0, portalSel, page, off};
  endfunction

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge CLK);
      #2;
    end
  endtask

  task automatic readBurst(input logic portalSel, input logic [6:0] page,
      input logic [4:0] off, input logic [3:0] len, input logic indLevel, input logic reqLevel);
    logic [5:0]  id;
    logic [4:0]  o;
    logic [31:0] word;
    int          k;
    id = 6'($urandom);
    o = off;
    for (k = 0; k <= int'(len); k++) begin
      word = 32'd0;
      if (!portalSel && page != 7'd0 && o == 5'd0) begin
        word = indWords[popIndex];  // next word of the indication stream.
        popIndex++;
      end
      expR.push_back({refRead(portalSel, page == 7'd0, o, indLevel, reqLevel, enModel, word),
                      id, k == int'(len)});
      o = o + 5'd4;
    end
    arAddr = makeAddr(portalSel, page, off);
    arLen = len;
    arId = id;
    arValid = 1'b1;
    do @(negedge CLK); while (!arReady);
    @(posedge CLK);
    #2 arValid = 1'b0;
    while (expR.size() != 0) idleCycles(1);
  endtask

  task automatic writeBurst(input logic portalSel, input logic [6:0] page,
      input logic [4:0] off, input logic [3:0] len, input logic [31:0] firstWord);
    logic [5:0]  id;
    logic [4:0]  o;
    logic [31:0] words [16];
    int          k;
    id = 6'($urandom);
    o = off;
    for (k = 0; k <= int'(len); k++) begin
      words[k] = (k == 0) ? firstWord : $urandom;
      if (portalSel && page != 7'd0) expReq.push_back({page[1:0] - 2'd1, words[k]});
      if (!portalSel && page == 7'd0 && o == 5'h04) enModel = words[k][0];
      o = o + 5'd4;
    end
    expB.push_back(id);
    awAddr = makeAddr(portalSel, page, off);
    awLen = len;
    awId = id;
    awValid = 1'b1;
    do @(negedge CLK); while (!awReady);
    @(posedge CLK);
    #2 awValid = 1'b0;
    for (k = 0; k <= int'(len); k++) begin
      wData = words[k];
      wValid = 1'b1;
      do @(negedge CLK); while (!wReady);
      @(posedge CLK);
      #2 wValid = 1'b0;
    end
    while (expB.size() != 0 || expReq.size() != 0) idleCycles(1);
  endtask

  task automatic checkIrq(input int cycles);
    repeat (cycles) begin
      @(negedge CLK);
      assert (irq == (enModel && indValid)) else
        logError($sformatf("irq %b with enable %b and indValid %b", irq, enModel, indValid));
      @(posedge CLK);
      #2;
    end
  endtask

  // ------------------------------
  // application and ready models
  initial begin
    logic popSeen;
    forever begin
      @(negedge CLK);
      popSeen = indPop;
      @(posedge CLK);
      #2;
      if (popSeen) indHead++;
      indData = indWords[indHead];
      indValid = indMode == 1 || (indMode == 2 && $urandom % 4 != 0);
      reqReady = !reqGaps || $urandom % 3 != 0;
      rReady = !rGaps || $urandom % 3 != 0;
      bReady = !bGaps || $urandom % 2 != 0;
    end
  end

  // ------------------------------
  // comparator
  initial begin
    logic [38:0] rExp;
    logic [33:0] qExp;
    forever begin
      @(negedge CLK);
      if (RST_N && rValid && rReady) begin
        assert (expR.size() != 0) else begin
          errors++;
          $display("a read beat arrived while none was expected");
        end
        if (expR.size() != 0) begin
          rExp = expR.pop_front();
          assert ({rData, rId, rLast} == rExp) else
            logError($sformatf("read beat %h/%h/%b, expected %h/%h/%b", rData, rId, rLast,
                               rExp[38:7], rExp[6:1], rExp[0]));
        end
      end
      if (RST_N && bValid && bReady) begin
        assert (expB.size() != 0) else begin
          errors++;
          $display("a write response arrived while none was expected");
        end
        if (expB.size() != 0) begin
          assert (bId == expB[0]) else logError($sformatf("bId %h, expected %h", bId, expB[0]));
          void'(expB.pop_front());
        end
      end
      if (RST_N && indPop) begin
        assert (indValid) else begin
          errors++;
          $display("an indication word was popped while none was waiting");
        end
      end
      if (RST_N && reqPush) begin
        assert (reqReady) else begin
          errors++;
          $display("a request was pushed while reqReady was low");
        end
        assert (expReq.size() != 0) else begin
          errors++;
          $display("a request was pushed while none was expected");
        end
        if (expReq.size() != 0) begin
          qExp = expReq.pop_front();
          assert ({reqMethod, reqData} == qExp) else
            logError($sformatf("request %0d/%h, expected %0d/%h", reqMethod, reqData,
                               qExp[33:32], qExp[31:0]));
        end
      end
    end
  end

  // ------------------------------
  // watchdog
  initial begin
    #(timeoutCycles * 20);
    $display("timeout: the run did not finish within %0d cycles", timeoutCycles);
    $display("Verification failed");
    $finish;
  end

  initial begin
    int i;
    int kind;
    int w;
    arAddr = '0;
    arLen = '0;
    arId = '0;
    arValid = 1'b0;
    rReady = 1'b1;
    awAddr = '0;
    awLen = '0;
    awId = '0;
    awValid = 1'b0;
    wData = '0;
    wValid = 1'b0;
    bReady = 1'b1;
    indData = '0;
    indValid = 1'b0;
    reqReady = 1'b1;
    void'($urandom(78452));
    foreach (indWords[j]) indWords[j] = $urandom;
    @(posedge RST_N);
    @(negedge CLK);
    assert (!rValid && !bValid && !indPop && !reqPush && !irq && arReady && awReady) else
      logError("outputs not idle after reset");
    idleCycles(1);

    // control pages, both indValid levels.
    indMode = 1;
    idleCycles(1);
    readBurst(1'b0, 7'd0, 5'd0, 4'd7, 1'b1, 1'b1);
    readBurst(1'b1, 7'd0, 5'd0, 4'd7, 1'b1, 1'b1);
    indMode = 0;
    idleCycles(1);
    readBurst(1'b0, 7'd0, 5'd0, 4'd7, 1'b0, 1'b1);
    readBurst(1'b0, 7'd1, 5'd4, 4'd3, 1'b0, 1'b1);
    readBurst(1'b1, 7'd2, 5'd0, 4'd3, 1'b0, 1'b1);

    // interrupt enable and irq.
    writeBurst(1'b0, 7'd0, 5'd4, 4'd0, 32'd1);
    readBurst(1'b0, 7'd0, 5'd4, 4'd0, 1'b0, 1'b1);
    indMode = 2;
    checkIrq(20);
    writeBurst(1'b0, 7'd0, 5'd4, 4'd0, 32'd0);
    readBurst(1'b0, 7'd0, 5'd4, 4'd0, 1'b0, 1'b1);
    checkIrq(20);

    // request writes while reqReady stalls.
    reqGaps = 1'b1;
    bGaps = 1'b1;
    repeat (6) writeBurst(1'b1, 7'($urandom % 127 + 1), 5'($urandom % 8 * 4),
                          4'($urandom), $urandom);

    // indication pops, steady and with gaps.
    indMode = 1;
    rGaps = 1'b1;
    idleCycles(1);
    readBurst(1'b0, 7'd1, 5'd0, 4'd15, 1'b1, 1'b1);
    readBurst(1'b0, 7'd3, 5'd0, 4'd0, 1'b1, 1'b1);
    readBurst(1'b0, 7'd9, 5'd0, 4'd0, 1'b1, 1'b1);
    indMode = 2;
    repeat (4) readBurst(1'b0, 7'd1, 5'd24, 4'd2, 1'b0, 1'b1);

    // ------------------------------
    // mixed traffic
    for (i = 0; i < mixedBursts; i++) begin
      kind = $urandom % 5;
      w = 2 + $urandom % 6;
      case (kind)
        0: begin
          indMode = 2;
          readBurst(1'b0, 7'($urandom % 127 + 1), 5'(w * 4), 4'($urandom % (9 - w)),
                    1'b0, 1'b1);  // ends on a pop at most.
        end
        1: begin
          indMode = 1;
          idleCycles(1);
          readBurst(1'($urandom), 7'd0, 5'($urandom % 8 * 4), 4'($urandom), 1'b1, 1'b1);
        end
        2: begin
          reqGaps = 1'b0;
          idleCycles(1);
          readBurst(1'b1, 7'($urandom % 127 + 1), 5'($urandom % 8 * 4), 4'($urandom),
                    1'b0, 1'b1);
          reqGaps = 1'b1;
        end
        3: writeBurst(1'b1, 7'($urandom % 127 + 1), 5'($urandom % 8 * 4), 4'($urandom),
                      $urandom);
        default: writeBurst(1'($urandom), 7'd0, 5'($urandom % 8 * 4), 4'($urandom), $urandom);
      endcase
    end

    idleCycles(5);
    assert (indHead == popIndex) else
      logError($sformatf("%0d indication words popped, expected %0d", indHead, popIndex));
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/tbClock.sv ====
`default_nettype none

module tbClock (
  output logic CLK,
  output logic RST_N
);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = !CLK;  // 20 unit period.
  end

  initial begin
    RST_N = 1'b0;
    repeat (8) @(posedge CLK);
    #2 RST_N = 1'b1;  // released in step with the stimulus.
  end

endmodule

`default_nettype wire

// ==== src/portalTop.sv ====
`default_nettype none

module portalTop import portalPkg::*; (
  input  wire logic                   CLK,
  input  wire logic                   RST_N,
  input  wire logic [addrWidth-1:0]   arAddr,
  input  wire logic [lenWidth-1:0]    arLen,
  input  wire logic [idWidth-1:0]     arId,
  input  wire logic                   arValid,
  output logic                        arReady,
  output logic [dataWidth-1:0]        rData,
  output logic [idWidth-1:0]          rId,
  output logic                        rLast,
  output logic                        rValid,
  input  wire logic                   rReady,
  input  wire logic [addrWidth-1:0]   awAddr,
  input  wire logic [lenWidth-1:0]    awLen,
  input  wire logic [idWidth-1:0]     awId,
  input  wire logic                   awValid,
  output logic                        awReady,
  input  wire logic [dataWidth-1:0]   wData,
  input  wire logic                   wValid,
  output logic                        wReady,
  output logic [idWidth-1:0]          bId,
  output logic                        bValid,
  input  wire logic                   bReady,
  input  wire logic [dataWidth-1:0]   indData,
  input  wire logic                   indValid,
  output logic                        indPop,
  input  wire logic                   reqReady,
  output logic [dataWidth-1:0]        reqData,
  output logic [methodWidth-1:0]      reqMethod,
  output logic                        reqPush,
  output logic                        irq
);

  logic [offsetWidth-1:0] rdOffset, wrOffset;
  logic [idWidth-1:0]     rdId, wrId;
  logic                   rdLast, wrLast;
  logic                   rdPush, wrPush;
  logic                   rdRoom, wrRoom;
  logic                   rdSplitReady, wrSplitReady;
  logic                   rdPortal, wrPortal;
  logic                   rdControl, wrControl;
  logic [methodWidth-1:0] wrMethod;
  logic [beatWidth-1:0]   rdBeat, wrBeat;
  logic                   rdBeatReady, wrBeatReady;
  logic                   rdBeatPop, wrBeatPop;
  logic                   intrEnable;

  // a new burst waits until the previous one has drained, the page flags sit beside the beats.
  assign arReady = rdSplitReady && !rdBeatReady;
  assign awReady = wrSplitReady && !wrBeatReady;
  assign irq     = intrEnable && indValid;

  // ------------------------------
  // read path
  burstSplitter readSplitter (
    .CLK (CLK), .RST_N (RST_N),
    .addr (arAddr), .len (arLen), .id (arId),
    .valid (arValid && !rdBeatReady), .ready (rdSplitReady),
    .beatOffset (rdOffset), .beatId (rdId), .beatLast (rdLast),
    .beatPush (rdPush), .beatRoom (rdRoom),
    .portal (rdPortal), .controlPage (rdControl), .method ()
  );

  beatFifo #(.width(beatWidth)) readBeats (
    .CLK (CLK), .RST_N (RST_N),
    .inData ({rdOffset, rdId, rdLast}), .push (rdPush), .notFull (rdRoom),
    .outData (rdBeat), .pop (rdBeatPop), .notEmpty (rdBeatReady)
  );

  portalRead reader (
    .CLK (CLK), .RST_N (RST_N),
    .beat (rdBeat), .beatReady (rdBeatReady), .beatPop (rdBeatPop),
    .portal (rdPortal), .controlPage (rdControl), .intrEnable (intrEnable),
    .indData (indData), .indValid (indValid), .indPop (indPop), .reqReady (reqReady),
    .rData (rData), .rId (rId), .rLast (rLast), .rValid (rValid), .rReady (rReady)
  );

  // ------------------------------
  // write path
  burstSplitter writeSplitter (
    .CLK (CLK), .RST_N (RST_N),
    .addr (awAddr), .len (awLen), .id (awId),
    .valid (awValid && !wrBeatReady), .ready (wrSplitReady),
    .beatOffset (wrOffset), .beatId (wrId), .beatLast (wrLast),
    .beatPush (wrPush), .beatRoom (wrRoom),
    .portal (wrPortal), .controlPage (wrControl), .method (wrMethod)
  );

  beatFifo #(.width(beatWidth)) writeBeats (
    .CLK (CLK), .RST_N (RST_N),
    .inData ({wrOffset, wrId, wrLast}), .push (wrPush), .notFull (wrRoom),
    .outData (wrBeat), .pop (wrBeatPop), .notEmpty (wrBeatReady)
  );

  portalWrite writer (
    .CLK (CLK), .RST_N (RST_N),
    .beat (wrBeat), .beatReady (wrBeatReady), .beatPop (wrBeatPop),
    .portal (wrPortal), .controlPage (wrControl), .method (wrMethod),
    .wData (wData), .wValid (wValid), .wReady (wReady),
    .reqReady (reqReady), .reqData (reqData), .reqMethod (reqMethod), .reqPush (reqPush),
    .intrEnable (intrEnable), .bId (bId), .bValid (bValid), .bReady (bReady)
  );

endmodule

`default_nettype wire

// ==== src/portalWrite.sv ====
`default_nettype none

module portalWrite import portalPkg::*; (
  input  wire logic                   CLK,
  input  wire logic                   RST_N,
  input  wire logic [beatWidth-1:0]   beat,
  input  wire logic                   beatReady,
  output logic                        beatPop,
  input  wire logic                   portal,
  input  wire logic                   controlPage,
  input  wire logic [methodWidth-1:0] method,
  input  wire logic [dataWidth-1:0]   wData,
  input  wire logic                   wValid,
  output logic                        wReady,
  input  wire logic                   reqReady,
  output logic [dataWidth-1:0]        reqData,
  output logic [methodWidth-1:0]      reqMethod,
  output logic                        reqPush,
  output logic                        intrEnable,
  output logic [idWidth-1:0]          bId,
  output logic                        bValid,
  input  wire logic                   bReady
);

  logic [offsetWidth-1:0] offset;
  logic [idWidth-1:0]     id;
  logic                   last;
  logic                   dataReady;
  logic                   reqWrite;
  logic                   enableWrite;
  logic                   service;

  assign {offset, id, last} = beat;

  // ------------------------------
  // write data queue
  beatFifo #(
    .width (dataWidth)
  ) writeData (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .inData   (wData),
    .push     (wValid),
    .notFull  (wReady),
    .outData  (reqData),
    .pop      (service),
    .notEmpty (dataReady)
  );

  assign reqWrite    = portal && !controlPage;
  assign enableWrite = !portal && controlPage && offset == regIntrEnable;

  // the last beat also needs a free response slot.
  assign service = beatReady && dataReady && (!reqWrite || reqReady) && (!last || !bValid);

  assign beatPop   = service;
  assign reqPush   = service && reqWrite;
  assign reqMethod = method;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      intrEnable <= 1'b0;
      bValid     <= 1'b0;
    end else begin
      if (service && enableWrite) intrEnable <= reqData[0];
      if (service && last) bValid <= 1'b1;
      else if (bReady) bValid <= 1'b0;  // one response per burst.
    end
  end

  always_ff @(posedge CLK) begin
    if (service && last) bId <= id;
  end

endmodule

`default_nettype wire

// ==== src/portalRead.sv ====
`default_nettype none

module portalRead import portalPkg::*; (
  input  wire logic                 CLK,
  input  wire logic                 RST_N,
  input  wire logic [beatWidth-1:0] beat,
  input  wire logic                 beatReady,
  output logic                      beatPop,
  input  wire logic                 portal,
  input  wire logic                 controlPage,
  input  wire logic                 intrEnable,
  input  wire logic [dataWidth-1:0] indData,
  input  wire logic                 indValid,
  output logic                      indPop,
  input  wire logic                 reqReady,
  output logic [dataWidth-1:0]      rData,
  output logic [idWidth-1:0]        rId,
  output logic                      rLast,
  output logic                      rValid,
  input  wire logic                 rReady
);

  logic [offsetWidth-1:0] offset;
  logic [idWidth-1:0]     id;
  logic                   last;
  logic [dataWidth-1:0]   readValue;
  logic                   popRead;
  logic                   outRoom;
  logic                   service;

  assign {offset, id, last} = beat;

  // ------------------------------
  // register map decode
  always_comb begin
    readValue = '0;
    if (controlPage) begin
      case (offset)
        regStatus, regChannel: readValue = portal ? '0 : dataWidth'(indValid);
        regIntrEnable: readValue = portal ? '0 : dataWidth'(intrEnable);
        regIdCount: readValue = idCountValue;
        regTopId: readValue = portal ? reqTopIdValue : indTopIdValue;
        regVersion: readValue = versionValue;
        default: readValue = '0;
      endcase
    end else if (portal) begin
      if (offset == regDataFlag) readValue = dataWidth'(reqReady);  // room for a request.
    end else begin
      case (offset)
        regDataPop: readValue = indData;
        regDataFlag: readValue = dataWidth'(indValid);  // word waiting.
        default: readValue = '0;
      endcase
    end
  end

  // a pop read stalls until a word is waiting.
  assign popRead = !portal && !controlPage && offset == regDataPop;
  assign service = beatReady && outRoom && (!popRead || indValid);
  assign beatPop = service;
  assign indPop  = service && popRead;

  // ------------------------------
  // read data queue
  beatFifo #(
    .width (dataWidth + idWidth + 1)
  ) readData (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .inData   ({readValue, id, last}),
    .push     (service),
    .notFull  (outRoom),
    .outData  ({rData, rId, rLast}),
    .pop      (rReady),
    .notEmpty (rValid)
  );

endmodule

`default_nettype wire

// ==== src/beatFifo.sv ====
`default_nettype none

module beatFifo import portalPkg::*; #(
  parameter int width = 8
) (
  input  wire logic             CLK,
  input  wire logic             RST_N,
  input  wire logic [width-1:0] inData,
  input  wire logic             push,
  output logic                  notFull,
  output logic [width-1:0]      outData,
  input  wire logic             pop,
  output logic                  notEmpty
);

  logic [width-1:0] mem [fifoDepth];
  logic             wrPtr;
  logic             rdPtr;
  logic [1:0]       count;
  logic             doPush;
  logic             doPop;

  assign notFull  = count != 2'(fifoDepth);
  assign notEmpty = count != 2'd0;
  assign doPush   = push && notFull;
  assign doPop    = pop && notEmpty;
  assign outData  = mem[rdPtr];

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      wrPtr <= 1'b0;
      rdPtr <= 1'b0;
      count <= 2'd0;
    end else begin
      if (doPush) wrPtr <= !wrPtr;
      if (doPop) rdPtr <= !rdPtr;
      if (doPush && !doPop) count <= count + 2'd1;
      else if (doPop && !doPush) count <= count - 2'd1;
    end
  end

  always_ff @(posedge CLK) begin
    if (doPush) mem[wrPtr] <= inData;
  end

endmodule

`default_nettype wire

// ==== src/burstSplitter.sv ====
`default_nettype none

module burstSplitter import portalPkg::*; (
  input  wire logic                   CLK,
  input  wire logic                   RST_N,
  input  wire logic [addrWidth-1:0]   addr,
  input  wire logic [lenWidth-1:0]    len,
  input  wire logic [idWidth-1:0]     id,
  input  wire logic                   valid,
  output logic                        ready,
  output logic [offsetWidth-1:0]      beatOffset,
  output logic [idWidth-1:0]          beatId,
  output logic                        beatLast,
  output logic                        beatPush,
  input  wire logic                   beatRoom,
  output logic                        portal,
  output logic                        controlPage,
  output logic [methodWidth-1:0]      method
);

  logic                busy;
  logic [lenWidth-1:0] beatsLeft;  // beats still to emit, minus one.

  assign ready    = !busy;
  assign beatPush = busy && beatRoom;
  assign beatLast = beatsLeft == '0;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      busy <= 1'b0;
    end else if (valid && ready) begin
      busy <= 1'b1;
    end else if (beatPush && beatLast) begin
      busy <= 1'b0;
    end
  end

  // burst fields, held for the whole burst.
  always_ff @(posedge CLK) begin
    if (valid && ready) begin
      beatOffset  <= addr[offsetWidth-1:0];
      beatsLeft   <= len;
      beatId      <= id;
      portal      <= addr[portalSelectBit];
      controlPage <= addr[pageHigh:pageLow] == '0;
      method      <= addr[methodLow +: methodWidth] - methodWidth'(1);  // method numbers start at 1.
    end else if (beatPush) begin
      beatOffset <= beatOffset + offsetWidth'(wordStep);  // wraps inside the page.
      beatsLeft  <= beatsLeft - lenWidth'(1);
    end
  end

endmodule

`default_nettype wire

// ==== src/portalPkg.sv ====
`default_nettype none

package portalPkg;

  // ------------------------------
  // widths
  localparam int dataWidth   = 32;
  localparam int addrWidth   = 32;
  localparam int idWidth     = 6;
  localparam int lenWidth    = 4;  // burst length minus one.
  localparam int offsetWidth = 5;
  localparam int methodWidth = 2;
  localparam int wordStep    = 4;  // bytes per beat.
  localparam int fifoDepth   = 2;
  localparam int beatWidth   = offsetWidth + idWidth + 1;  // offset, id, last.

  // ------------------------------
  // address fields
  localparam int portalSelectBit = 12;  // 0 indication, 1 request.
  localparam int pageLow         = 5;
  localparam int pageHigh        = 11;  // all zero selects the control page.
  localparam int methodLow       = 5;

  // ------------------------------
  // register offsets
  localparam logic [offsetWidth-1:0] regStatus     = 5'h00;
  localparam logic [offsetWidth-1:0] regIntrEnable = 5'h04;
  localparam logic [offsetWidth-1:0] regIdCount    = 5'h08;
  localparam logic [offsetWidth-1:0] regChannel    = 5'h0C;
  localparam logic [offsetWidth-1:0] regTopId      = 5'h10;
  localparam logic [offsetWidth-1:0] regVersion    = 5'h14;
  localparam logic [offsetWidth-1:0] regDataPop    = 5'h00;
  localparam logic [offsetWidth-1:0] regDataFlag   = 5'h04;

  // info register contents
  localparam logic [dataWidth-1:0] idCountValue  = 32'd1;
  localparam logic [dataWidth-1:0] indTopIdValue = 32'd5;
  localparam logic [dataWidth-1:0] reqTopIdValue = 32'd6;
  localparam logic [dataWidth-1:0] versionValue  = 32'd2;

endpackage

`default_nettype wire
